// File: source/issue_defs.svh
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Architectural integer registers, x0 included
`define REG_COUNT 32

// Integer data path width
`define XLEN 32

// Bubbles pushed into execute behind a taken branch or jump
// Covers the fetch and decode slots that followed the wrong path
`define KILL_SLOTS 2

`endif

// File: source/issuePkg.sv
`include "issue_defs.svh"

package issuePkg;

	// Plain vector types with a fixed meaning
	typedef logic [4:0] regAddr;
	typedef logic [`XLEN-1:0] word;
	typedef logic [3:0] aluFn;
	typedef logic [2:0] funct3;
	// Zero means no memory access
	typedef logic [3:0] memOp;
	typedef logic [2:0] mulDivOp;

	// Source of execute operand B
	typedef enum logic [1:0]
	{
		REG_B,
		IMM_B,
		SHAMT_B
	} bSel;

	// Instruction as handed over by decode
	typedef struct packed
	{
		logic writeEn;
		regAddr rd;
		logic useRs1;
		logic useRs2;
		logic isBranch;
		logic branchNe;
		logic jump;
		logic jumpReg;
		logic lui;
		logic auipc;
		aluFn alu;
		funct3 fn3;
		memOp mem;
		mulDivOp mulDiv;
		bSel opBSel;
		word immI;
		word immB;
		word immJ;
		word immS;
		word immU;
		logic [4:0] shamt;
		word pc;
		logic [1:0] pcSelect;
	} decodedInstr;

	// Instruction as seen by execute
	// I immediate and shamt already folded into opB
	typedef struct packed
	{
		logic writeEn;
		regAddr rd;
		logic isBranch;
		logic branchNe;
		logic jump;
		logic jumpReg;
		logic lui;
		logic auipc;
		aluFn alu;
		funct3 fn3;
		memOp mem;
		mulDivOp mulDiv;
		word immB;
		word immJ;
		word immS;
		word immU;
		word pc;
		logic [1:0] pcSelect;
		word opA;
		word opB;
	} issuedInstr;

	// No-op with no register write, operand B from a zero immediate
	function automatic decodedInstr makeBubble();
		decodedInstr b;
		b = '0;
		b.opBSel = IMM_B;
		return b;
	endfunction

	localparam decodedInstr bubble = makeBubble();

endpackage

// File: source/registerFile.sv
`timescale 1ns/1ps
`include "issue_defs.svh"

module registerFile
	import issuePkg::*;
(
	input logic clk,
	input logic nrst,
	// Commit writeback port
	input logic wbEn,
	input regAddr wbAddr,
	input word wbData,
	// Source addresses straight from decode
	input regAddr rs1,
	input regAddr rs2,
	output word rdA,
	output word rdB
);

	// Entry 0 is kept for indexing only and never written
	word regs [0:`REG_COUNT-1];

	// Writes to x0 are dropped here
	logic wbLive;

	assign wbLive = wbEn && (wbAddr != '0);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 0; i < `REG_COUNT; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (wbLive)
		begin
			regs[wbAddr] <= wbData;
		end
	end

	// Combinational read ports
	// Same-cycle writeback bypasses the array so issue sees the new value
	assign rdA = (wbLive && (wbAddr == rs1)) ? wbData : regs[rs1];
	assign rdB = (wbLive && (wbAddr == rs2)) ? wbData : regs[rs2];

endmodule

// File: source/hazardScoreboard.sv
`timescale 1ns/1ps
`include "issue_defs.svh"

module hazardScoreboard
	import issuePkg::*;
(
	input logic clk,
	input logic nrst,
	input decodedInstr decIn,
	input regAddr rs1,
	input regAddr rs2,
	// Commit writeback, clears pending bits
	input logic wbEn,
	input regAddr wbAddr,
	// Redirect from execute
	input logic branchTaken,
	// Memory unit holding execute
	input logic memHold,
	output logic stall,
	output logic kill
);

	// Wide enough to hold KILL_SLOTS - 1 for any slot count
	localparam int CntW = $clog2(`KILL_SLOTS + 1);

	// One bit per architectural register, set while a write is in flight
	logic [`REG_COUNT-1:0] pending;
	logic [`REG_COUNT-1:0] setMask;
	logic [`REG_COUNT-1:0] clearMask;
	// Remaining kill slots after the branchTaken edge
	logic [CntW-1:0] killCnt;
	logic accept;
	logic hazA;
	logic hazB;

	// RAW check only on sources that decode marks as used
	// x0 never hazards
	assign hazA = decIn.useRs1 && (rs1 != '0) && pending[rs1];
	assign hazB = decIn.useRs2 && (rs2 != '0) && pending[rs2];
	assign stall = hazA || hazB;

	// Kill covers the branchTaken cycle and the counted slots behind it
	assign kill = branchTaken || (killCnt != '0);

	// Decode slot goes through only with no stall, kill or hold
	assign accept = !stall && !kill && !memHold;

	always_comb
	begin
		setMask = '0;
		clearMask = '0;
		if (accept && decIn.writeEn && (decIn.rd != '0))
		begin
			setMask[decIn.rd] = 1'b1;
		end
		if (wbEn)
		begin
			clearMask[wbAddr] = 1'b1;
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			pending <= '0;
			killCnt <= '0;
		end
		else
		begin
			// Set beats clear on the same edge
			pending <= (pending & ~clearMask) | setMask;
			if (branchTaken)
			begin
				killCnt <= CntW'(`KILL_SLOTS - 1);
			end
			else if (killCnt != '0)
			begin
				killCnt <= killCnt - 1'b1;
			end
		end
	end

	// Execute holds bubbles during a kill, so no new redirect may stretch it
	assert property (@(posedge clk) disable iff (!nrst)
		kill [*`KILL_SLOTS] |=> !kill)
	else
		$error("kill lasted longer than the bubble slots");

endmodule

// File: source/issueRegister.sv
`timescale 1ns/1ps

module issueRegister
	import issuePkg::*;
(
	input logic clk,
	input logic nrst,
	input decodedInstr decIn,
	// Register file values for rs1 and rs2
	input word rdA,
	input word rdB,
	input logic stall,
	input logic kill,
	input logic memHold,
	output issuedInstr issueOut
);

	// Maps a decoded instruction and its operands onto the execute format
	function automatic issuedInstr toIssued(decodedInstr d, word a, word b);
		issuedInstr o;
		o.writeEn = d.writeEn;
		o.rd = d.rd;
		o.isBranch = d.isBranch;
		o.branchNe = d.branchNe;
		o.jump = d.jump;
		o.jumpReg = d.jumpReg;
		o.lui = d.lui;
		o.auipc = d.auipc;
		o.alu = d.alu;
		o.fn3 = d.fn3;
		o.mem = d.mem;
		o.mulDiv = d.mulDiv;
		o.immB = d.immB;
		o.immJ = d.immJ;
		o.immS = d.immS;
		o.immU = d.immU;
		o.pc = d.pc;
		o.pcSelect = d.pcSelect;
		o.opA = a;
		o.opB = b;
		return o;
	endfunction

	// Bubble in execute format, opB taken from its zero I immediate
	localparam issuedInstr issuedBubble = toIssued(bubble, '0, bubble.immI);

	word opBMux;
	issuedInstr loaded;

	// Operand B source
	always_comb
	begin
		unique case (decIn.opBSel)
			REG_B: opBMux = rdB;
			IMM_B: opBMux = decIn.immI;
			// Shift amount zero-extended
			SHAMT_B: opBMux = word'(decIn.shamt);
			default: opBMux = rdB;
		endcase
	end

	assign loaded = toIssued(decIn, rdA, opBMux);

	// Priority is kill, then memory hold, then stall
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			issueOut <= issuedBubble;
		end
		else if (kill)
		begin
			// Wrong-path slot is dropped
			issueOut <= issuedBubble;
		end
		else if (memHold)
		begin
			issueOut <= issueOut;
		end
		else if (stall)
		begin
			// Decode keeps the instruction, execute gets a no-op
			issueOut <= issuedBubble;
		end
		else
		begin
			issueOut <= loaded;
		end
	end

	// Decode keeps a stalled instruction in place until it can go through
	assert property (@(posedge clk) disable iff (!nrst)
		(stall && !kill) |=> $stable(decIn))
	else
		$error("decode changed its instruction during a stall");

endmodule

// File: source/issueTop.sv
`timescale 1ns/1ps

module issueTop
	import issuePkg::*;
(
	input logic clk,
	input logic nrst,
	// From decode
	input decodedInstr decIn,
	input regAddr rs1,
	input regAddr rs2,
	// From commit
	input logic wbEn,
	input regAddr wbAddr,
	input word wbData,
	// From execute and memory
	input logic branchTaken,
	input logic memHold,
	// Back to decode
	output logic stall,
	// Toward execute
	output issuedInstr issueOut
);

	word rdA;
	word rdB;
	logic kill;

	// Source operand storage
	registerFile regFile (
		.clk(clk),
		.nrst(nrst),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.rs1(rs1),
		.rs2(rs2),
		.rdA(rdA),
		.rdB(rdB)
	);

	// RAW stall and branch kill
	hazardScoreboard scoreboard (
		.clk(clk),
		.nrst(nrst),
		.decIn(decIn),
		.rs1(rs1),
		.rs2(rs2),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.branchTaken(branchTaken),
		.memHold(memHold),
		.stall(stall),
		.kill(kill)
	);

	// Pipeline register toward execute
	issueRegister issueReg (
		.clk(clk),
		.nrst(nrst),
		.decIn(decIn),
		.rdA(rdA),
		.rdB(rdB),
		.stall(stall),
		.kill(kill),
		.memHold(memHold),
		.issueOut(issueOut)
	);

endmodule

// File: sim/issueTb.sv
`timescale 1ns/1ps
`include "issue_defs.svh"

module issueTb
	import issuePkg::*;
();

	localparam int NumRows = 26;
	localparam int ResetCycles = 8;

	// What issueOut should hold after the row's rising edge
	typedef enum logic [1:0]
	{
		EXP_ISSUE,
		EXP_BUBBLE,
		EXP_HOLD
	} expKind;

	// One cycle of stimulus and its expected results
	typedef struct packed
	{
		decodedInstr d;
		regAddr rs1;
		regAddr rs2;
		logic wbEn;
		regAddr wbAddr;
		word wbData;
		logic br;
		logic hold;
		logic expStall;
		expKind kind;
	} rowT;

	logic clk;
	logic nrst;
	decodedInstr decIn;
	regAddr rs1;
	regAddr rs2;
	logic wbEn;
	regAddr wbAddr;
	word wbData;
	logic branchTaken;
	logic memHold;
	logic stall;
	issuedInstr issueOut;

	rowT rows [NumRows];
	int rowCount;
	// Reference copy of the architectural registers
	word refRegs [`REG_COUNT];
	issuedInstr expOut;
	issuedInstr bubbleOut;
	integer seed;
	int stallErrs;
	int outErrs;

	issueTop uut (
		.clk(clk),
		.nrst(nrst),
		.decIn(decIn),
		.rs1(rs1),
		.rs2(rs2),
		.wbEn(wbEn),
		.wbAddr(wbAddr),
		.wbData(wbData),
		.branchTaken(branchTaken),
		.memHold(memHold),
		.stall(stall),
		.issueOut(issueOut)
	);

	always #50 clk = ~clk;

	// Pass-through fields derived from the pc so each instruction is distinct
	function automatic decodedInstr makeInstr(logic we, regAddr rd, logic use1, logic use2,
		bSel sel, word immI, logic [4:0] sh, word pc);
		decodedInstr d;
		d = '0;
		d.writeEn = we;
		d.rd = rd;
		d.useRs1 = use1;
		d.useRs2 = use2;
		d.opBSel = sel;
		d.immI = immI;
		d.shamt = sh;
		d.pc = pc;
		// Control flags only ride along to execute
		d.isBranch = pc[2];
		d.branchNe = pc[3];
		d.jump = pc[4];
		d.jumpReg = ~pc[2];
		d.lui = ~pc[3];
		d.auipc = ~pc[4];
		d.mem = ~pc[5:2];
		d.alu = pc[5:2];
		d.fn3 = pc[4:2];
		d.mulDiv = rd[2:0];
		d.immB = pc + 32'h10;
		d.immJ = pc + 32'h20;
		d.immS = pc ^ 32'hff;
		d.immU = {pc[19:0], 12'h0};
		d.pcSelect = pc[3:2];
		return d;
	endfunction

	// Execute view of an accepted instruction
	// opA from rs1, opB picked by bSel, I immediate and shamt not carried
	function automatic issuedInstr expectIssue(decodedInstr d, regAddr a, regAddr b);
		issuedInstr e;
		e = '0;
		e.writeEn = d.writeEn;
		e.rd = d.rd;
		e.isBranch = d.isBranch;
		e.branchNe = d.branchNe;
		e.jump = d.jump;
		e.jumpReg = d.jumpReg;
		e.lui = d.lui;
		e.auipc = d.auipc;
		e.alu = d.alu;
		e.fn3 = d.fn3;
		e.mem = d.mem;
		e.mulDiv = d.mulDiv;
		e.immB = d.immB;
		e.immJ = d.immJ;
		e.immS = d.immS;
		e.immU = d.immU;
		e.pc = d.pc;
		e.pcSelect = d.pcSelect;
		e.opA = refRegs[a];
		case (d.opBSel)
			IMM_B: e.opB = d.immI;
			SHAMT_B: e.opB = {{(`XLEN-5){1'b0}}, d.shamt};
			default: e.opB = refRegs[b];
		endcase
		return e;
	endfunction

	// Appends a row, writeback data drawn from the seeded generator
	task automatic addRow(decodedInstr d, regAddr a, regAddr b, logic we, regAddr wa,
		logic br, logic hold, logic expStall, expKind kind);
		rowT r;
		r.d = d;
		r.rs1 = a;
		r.rs2 = b;
		r.wbEn = we;
		r.wbAddr = wa;
		r.wbData = we ? word'($random(seed)) : '0;
		r.br = br;
		r.hold = hold;
		r.expStall = expStall;
		r.kind = kind;
		rows[rowCount] = r;
		rowCount++;
	endtask

	task automatic buildTable();
		decodedInstr d;
		// Preload x1 to x3 behind no-ops
		addRow(bubble, 5'd0, 5'd0, 1'b1, 5'd1, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		addRow(bubble, 5'd0, 5'd0, 1'b1, 5'd2, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		addRow(bubble, 5'd0, 5'd0, 1'b1, 5'd3, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// x4 = x1 op x2, leaves x4 pending
		d = makeInstr(1'b1, 5'd4, 1'b1, 1'b1, REG_B, 32'h0, 5'd0, 32'h100);
		addRow(d, 5'd1, 5'd2, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// Reads x5 while commit writes it, rs2 is x0
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b1, REG_B, 32'h0, 5'd0, 32'h104);
		addRow(d, 5'd5, 5'd0, 1'b1, 5'd5, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// opB from the I immediate
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b0, IMM_B, word'($random(seed)), 5'd0, 32'h108);
		addRow(d, 5'd3, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// opB from shamt, immI and x2 must both be ignored
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b0, SHAMT_B, 32'hdead_beef, 5'd19, 32'h10c);
		addRow(d, 5'd1, 5'd2, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// RAW on x4, held by decode until commit
		d = makeInstr(1'b1, 5'd6, 1'b1, 1'b1, REG_B, 32'h0, 5'd0, 32'h110);
		addRow(d, 5'd4, 5'd2, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, EXP_BUBBLE);
		addRow(d, 5'd4, 5'd2, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, EXP_BUBBLE);
		addRow(d, 5'd4, 5'd2, 1'b1, 5'd4, 1'b0, 1'b0, 1'b1, EXP_BUBBLE);
		addRow(d, 5'd4, 5'd2, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// Taken branch, two wrong-path writers dropped
		d = makeInstr(1'b1, 5'd7, 1'b0, 1'b0, IMM_B, 32'h1, 5'd0, 32'h114);
		addRow(d, 5'd0, 5'd0, 1'b0, 5'd0, 1'b1, 1'b0, 1'b0, EXP_BUBBLE);
		d = makeInstr(1'b1, 5'd8, 1'b0, 1'b0, IMM_B, 32'h2, 5'd0, 32'h118);
		addRow(d, 5'd0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_BUBBLE);
		// Branch target, commit of x6 alongside
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b0, IMM_B, 32'h7ff, 5'd0, 32'h200);
		addRow(d, 5'd1, 5'd0, 1'b1, 5'd6, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// x7 and x8 never became pending
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b1, REG_B, 32'h0, 5'd0, 32'h204);
		addRow(d, 5'd7, 5'd8, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// Commit aimed at x0 while reading it, x0 stays zero
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b1, REG_B, 32'h0, 5'd0, 32'h208);
		addRow(d, 5'd0, 5'd3, 1'b1, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// Three cycles of memory hold
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b0, IMM_B, word'($random(seed)), 5'd0, 32'h20c);
		addRow(d, 5'd1, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 1'b0, EXP_HOLD);
		addRow(d, 5'd1, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 1'b0, EXP_HOLD);
		addRow(d, 5'd1, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 1'b0, EXP_HOLD);
		addRow(d, 5'd1, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		// Stall overlapping a hold
		d = makeInstr(1'b1, 5'd9, 1'b1, 1'b0, IMM_B, 32'h10, 5'd0, 32'h210);
		addRow(d, 5'd3, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		d = makeInstr(1'b0, 5'd0, 1'b1, 1'b0, SHAMT_B, 32'h0, 5'd7, 32'h214);
		addRow(d, 5'd9, 5'd0, 1'b0, 5'd0, 1'b0, 1'b1, 1'b1, EXP_HOLD);
		addRow(d, 5'd9, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b1, EXP_BUBBLE);
		addRow(d, 5'd9, 5'd0, 1'b1, 5'd9, 1'b0, 1'b0, 1'b1, EXP_BUBBLE);
		addRow(d, 5'd9, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
		addRow(bubble, 5'd0, 5'd0, 1'b0, 5'd0, 1'b0, 1'b0, 1'b0, EXP_ISSUE);
	endtask

	// Drives one row and works out what execute should see next
	task automatic applyRow(rowT r);
		decIn = r.d;
		rs1 = r.rs1;
		rs2 = r.rs2;
		wbEn = r.wbEn;
		wbAddr = r.wbAddr;
		wbData = r.wbData;
		branchTaken = r.br;
		memHold = r.hold;
		// Commit lands before the read, same as write-through
		if (r.wbEn && (r.wbAddr != '0))
		begin
			refRegs[r.wbAddr] = r.wbData;
		end
		case (r.kind)
			EXP_ISSUE: expOut = expectIssue(r.d, r.rs1, r.rs2);
			EXP_BUBBLE: expOut = bubbleOut;
			default: expOut = expOut;
		endcase
	endtask

	task automatic compareStall(logic got, logic exp, string what);
		if (got !== exp)
		begin
			stallErrs++;
			$display("ERROR at %0d ns: %s stall is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic compareOut(issuedInstr got, issuedInstr exp, string what);
		if (got !== exp)
		begin
			outErrs++;
			$display("ERROR at %0d ns: %s issueOut pc %h opA %h opB %h, expected pc %h opA %h opB %h",
				$time, what, got.pc, got.opA, got.opB, exp.pc, exp.opA, exp.opB);
		end
	endtask

	initial
	begin
		seed = 32'hdcbb_b50c;
		stallErrs = 0;
		outErrs = 0;
		rowCount = 0;
		clk = 1'b0;
		nrst = 1'b0;
		decIn = bubble;
		rs1 = '0;
		rs2 = '0;
		wbEn = 1'b0;
		wbAddr = '0;
		wbData = '0;
		branchTaken = 1'b0;
		memHold = 1'b0;
		for (int i = 0; i < `REG_COUNT; i++)
		begin
			refRegs[i] = '0;
		end
		bubbleOut = expectIssue(bubble, 5'd0, 5'd0);
		expOut = bubbleOut;
		buildTable();
		repeat (ResetCycles) @(posedge clk);
		@(negedge clk);
		nrst = 1'b1;
		#10;
		compareStall(stall, 1'b0, "after reset");
		compareOut(issueOut, bubbleOut, "after reset");
		// Stall is checked mid-cycle, issueOut on the following falling edge
		for (int i = 0; i < rowCount; i++)
		begin
			@(negedge clk);
			if (i > 0)
			begin
				compareOut(issueOut, expOut, $sformatf("row %0d", i - 1));
			end
			applyRow(rows[i]);
			#10;
			compareStall(stall, rows[i].expStall, $sformatf("row %0d", i));
		end
		@(negedge clk);
		compareOut(issueOut, expOut, $sformatf("row %0d", rowCount - 1));
		$display("Error counts: stall %0d, issueOut %0d", stallErrs, outErrs);
		if ((stallErrs + outErrs) == 0)
		begin
			$display("Testbench passed");
		end
		else
		begin
			$display("Testbench failed");
		end
		$finish;
	end

	// Reset plus table length plus slack, in 100 ns cycles
	initial
	begin
		#((NumRows + ResetCycles + 20) * 100);
		$display("Timeout: the run did not finish within %0d clock cycles",
			NumRows + ResetCycles + 20);
		$display("Testbench failed");
		$finish;
	end

endmodule

// File: issueStage.f
+incdir+source
source/issuePkg.sv
source/registerFile.sv
source/hazardScoreboard.sv
source/issueRegister.sv
source/issueTop.sv
sim/issueTb.sv

// File: run.sh
#!/bin/sh
# Build and run the issue stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module issueTb \
	-f issueStage.f -o issueSim

./obj_dir/issueSim > sim.log 2>&1
cat sim.log

if grep -q "^Testbench passed$" sim.log
then
	exit 0
fi
echo "Simulation did not report a pass"
exit 1
